// File: Makefile
# Verilator build and run for the LSU conformance monitor

VERILATOR ?= verilator
TOP       ?= tb_lsu_conformance
RTL_TOP   ?= lsu_conformance_top
FILELIST  ?= lsu_conformance_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0
PASS_MSG  ?= *** TEST PASSED ***

RTL_SRCS ?= verilog/mem_pkg.sv verilog/csr_pkg.sv verilog/mem_req_tracker.sv \
            verilog/resp_counter.sv verilog/csr_check_filter.sv \
            verilog/lsu_conformance_top.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: lsu_conformance_top.f
verilog/mem_pkg.sv
verilog/csr_pkg.sv
verilog/mem_req_tracker.sv
verilog/resp_counter.sv
verilog/csr_check_filter.sv
verilog/lsu_conformance_top.sv
tests/tb_lsu_conformance.sv

// File: tests/tb_lsu_conformance.sv
/*
  Testbench for the LSU conformance monitor
  Random instructions, bus traffic and CSR accesses from an LFSR,
  every output checked each cycle against a reference model
*/
`timescale 1ns/1ns

module tb_lsu_conformance import mem_pkg::*, csr_pkg::*;;

  localparam int unsigned CntWidth     = 8;
  localparam int          CntMax       = (1 << CntWidth) - 1;
  localparam int          NumInstr     = 300;
  localparam int          DrainTimeout = 300; // Cycles allowed to empty the counter

  typedef logic [CntWidth-1:0] cnt_t;

  logic      clk_i = 1'b0;
  logic      rst_n_i;
  logic      spec_valid_i;
  mem_op_t   spec_op_i;
  logic      instr_done_i;
  logic      data_req_i;
  bus_req_t  data_req_o_i;
  logic      data_gnt_i;
  logic      data_rvalid_i;
  logic      csr_access_i;
  csr_addr_t csr_addr_i;
  logic      req_mismatch_o;
  logic      unexpected_req_o;
  logic      resp_err_o;
  cnt_t      outstanding_o;
  logic      csr_uncheckable_o;

  logic [31:0] lfsr_q = 32'hf9a9a42b;

  // Reference model state
  int m_gnt_num;  // Grants seen in this instruction, stops at 2
  int m_count;    // Responses still owed
  int n_mism;     // Events seen, for a stimulus sanity check
  int n_unexp;
  int n_rerr;
  int n_csr;

  lsu_conformance_top #(
    .CntWidth (CntWidth)
  ) dut0 (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .spec_valid_i      (spec_valid_i),
    .spec_op_i         (spec_op_i),
    .instr_done_i      (instr_done_i),
    .data_req_i        (data_req_i),
    .data_req_o_i      (data_req_o_i),
    .data_gnt_i        (data_gnt_i),
    .data_rvalid_i     (data_rvalid_i),
    .csr_access_i      (csr_access_i),
    .csr_addr_i        (csr_addr_i),
    .req_mismatch_o    (req_mismatch_o),
    .unexpected_req_o  (unexpected_req_o),
    .resp_err_o        (resp_err_o),
    .outstanding_o     (outstanding_o),
    .csr_uncheckable_o (csr_uncheckable_o)
  );

  always #10 clk_i = ~clk_i; // 20 ns period

  // Galois LFSR, one step per bit
  function automatic logic next_bit();
    logic out;
    out    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) lfsr_q = lfsr_q ^ 32'hD000_0001;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // Byte enables spread to a 32-bit lane mask
  function automatic word_t lane_mask(input be_t be);
    return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
  endfunction

  function automatic logic half_matches(input mem_half_t h, input bus_req_t r);
    logic ok;
    ok = (r.we == h.write) && (~r.we == h.read);
    if (r.addr != h.addr) ok = 1'b0;
    if (r.we && (((r.wdata ^ h.wdata) & lane_mask(h.be)) != '0)) ok = 1'b0; // Enabled lanes only
    return ok;
  endfunction

  function automatic logic csr_is_uncheckable(input csr_addr_t a);
    logic hit;
    hit = 1'b0;
    if (a >= CSR_MHPMCOUNTER3 && a <= CSR_MHPMCOUNTER31) hit = 1'b1;
    if (a >= CSR_MHPMCOUNTER3H && a <= CSR_MHPMCOUNTER31H) hit = 1'b1;
    if (a >= CSR_MHPMEVENT3 && a <= CSR_MHPMEVENT31) hit = 1'b1;
    case (a)
      CSR_CPUCTRLSTS, CSR_SECURESEED, CSR_MIE, CSR_MCYCLE, CSR_MCYCLEH,
      CSR_MINSTRET, CSR_MINSTRETH, CSR_MCOUNTINHIBIT: hit = 1'b1;
      default: ;
    endcase
    return hit;
  endfunction

  // Half the picks are biased toward range edges and listed singles
  function automatic csr_addr_t pick_csr_addr();
    csr_addr_t a;
    logic      biased;
    logic [4:0] sel;
    biased = next_bit();
    sel    = 5'(rand_bits(5));
    a      = csr_addr_t'(rand_bits(12));
    if (biased) begin
      case (sel)
        5'd0:    a = CSR_MHPMCOUNTER3 - 12'd1;
        5'd1:    a = CSR_MHPMCOUNTER3;
        5'd2:    a = CSR_MHPMCOUNTER31;
        5'd3:    a = CSR_MHPMCOUNTER31 + 12'd1;
        5'd4:    a = CSR_MHPMCOUNTER3H - 12'd1;
        5'd5:    a = CSR_MHPMCOUNTER3H;
        5'd6:    a = CSR_MHPMCOUNTER31H;
        5'd7:    a = CSR_MHPMCOUNTER31H + 12'd1;
        5'd8:    a = CSR_MHPMEVENT3 - 12'd1;
        5'd9:    a = CSR_MHPMEVENT3;
        5'd10:   a = CSR_MHPMEVENT31;
        5'd11:   a = CSR_MHPMEVENT31 + 12'd1;
        5'd12:   a = CSR_CPUCTRLSTS;
        5'd13:   a = CSR_SECURESEED;
        5'd14:   a = CSR_SECURESEED + 12'd1;
        5'd15:   a = CSR_MIE;
        5'd16:   a = CSR_MIE + 12'd1;
        5'd17:   a = CSR_MCYCLE;
        5'd18:   a = CSR_MCYCLEH;
        5'd19:   a = CSR_MINSTRET;
        5'd20:   a = CSR_MINSTRETH;
        5'd21:   a = CSR_MCOUNTINHIBIT;
        default: ; // Keep the random address
      endcase
    end
    return a;
  endfunction

  function automatic mem_half_t make_half(input logic expected);
    mem_half_t h;
    h = '0;
    if (expected) begin
      h.write = next_bit();
      h.read  = ~h.write;
      h.addr  = word_t'(rand_bits(30)) << 2;
      h.wdata = rand_bits(32);
      h.be    = be_t'(rand_bits(4)); // Zero enables allowed
    end
    return h;
  endfunction

  task automatic fail_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_count(input cnt_t got, input cnt_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: outstanding_o got %0d expected %0d", $time, got, exp);
      fail_run();
    end
  endtask

  task automatic check_csr_flag(input csr_addr_t addr, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: csr_uncheckable_o (addr 0x%h) got %b expected %b",
               $time, addr, got, exp);
      fail_run();
    end
  endtask

  // Predict from the applied inputs, clock once, compare
  task automatic step_clock();
    logic      gnt;
    logic      exp_mism;
    logic      exp_unexp;
    logic      exp_rerr;
    logic      exp_csr;
    csr_addr_t addr;
    mem_half_t h;
    gnt       = data_req_i & data_gnt_i;
    exp_mism  = 1'b0;
    exp_unexp = 1'b0;
    addr      = csr_addr_i;
    if (gnt) begin
      if (!spec_valid_i || m_gnt_num >= 2 ||
          (m_gnt_num == 1 && !(spec_op_i.snd.read || spec_op_i.snd.write))) begin
        exp_unexp = 1'b1;
      end else begin
        h        = (m_gnt_num == 0) ? spec_op_i.fst : spec_op_i.snd;
        exp_mism = ~half_matches(h, data_req_o_i);
      end
      if (m_gnt_num < 2) m_gnt_num++;
    end
    if (instr_done_i) m_gnt_num = 0; // After this cycle's grant
    exp_rerr = data_rvalid_i && (m_count == 0);
    if (gnt && !data_rvalid_i && m_count < CntMax) m_count++;
    else if (!gnt && data_rvalid_i && m_count > 0) m_count--;
    exp_csr = csr_access_i && csr_is_uncheckable(addr);
    if (exp_mism) n_mism++;
    if (exp_unexp) n_unexp++;
    if (exp_rerr) n_rerr++;
    if (exp_csr) n_csr++;
    @(posedge clk_i);
    #1;
    check_flag("req_mismatch_o", req_mismatch_o, exp_mism);
    check_flag("unexpected_req_o", unexpected_req_o, exp_unexp);
    check_flag("resp_err_o", resp_err_o, exp_rerr);
    check_count(outstanding_o, cnt_t'(m_count));
    check_csr_flag(addr, csr_uncheckable_o, exp_csr);
    #1; // Back to the drive point
  endtask

  // Responses mostly while some are owed, rare spurious ones
  task automatic randomize_side_inputs();
    if (m_count > 0) data_rvalid_i = next_bit();
    else data_rvalid_i = (rand_bits(3) == 32'd0);
    csr_access_i = next_bit();
    csr_addr_i   = pick_csr_addr();
  endtask

  // Stalls, then one granted request, corrupted by kind 0 to 3
  task automatic send_request(input mem_half_t h, input logic [2:0] kind, input logic with_done);
    bus_req_t r;
    int       stalls;
    int       bit_idx;
    int       lane;
    stalls = int'(rand_bits(2));
    for (int s = 0; s < stalls; s++) begin
      data_req_i         = 1'b1;
      data_gnt_i         = 1'b0;
      data_req_o_i.we    = next_bit();       // Junk while not granted
      data_req_o_i.addr  = rand_bits(32);
      data_req_o_i.wdata = rand_bits(32);
      randomize_side_inputs();
      step_clock();
    end
    r       = '{we: h.write, be: h.be, addr: h.addr, wdata: h.wdata};
    bit_idx = int'(rand_bits(5));
    lane    = int'(rand_bits(2));
    case (kind)
      3'd0:    r.addr = r.addr ^ (word_t'(1) << bit_idx);
      3'd1:    r.we = ~r.we;
      3'd2:    r.wdata = r.wdata ^ (word_t'(8'h5a) << (lane * 8)); // May hit a disabled lane
      3'd3:    r.wdata = r.wdata ^ ~lane_mask(h.be);              // Disabled lanes only
      default: ;
    endcase
    data_req_i   = 1'b1;
    data_gnt_i   = 1'b1;
    data_req_o_i = r;
    instr_done_i = with_done;
    randomize_side_inputs();
    step_clock();
    data_req_i   = 1'b0;
    data_gnt_i   = 1'b0;
    instr_done_i = 1'b0;
  endtask

  task automatic run_instruction();
    mem_op_t op;
    logic    split;
    logic    extra;
    logic    merge_done;
    int      n_req;
    split        = next_bit();
    extra        = (rand_bits(2) == 32'd0); // One request too many
    merge_done   = next_bit();
    op.fst       = make_half(1'b1);
    op.snd       = make_half(split);
    n_req        = 1 + int'(split) + int'(extra);
    spec_op_i    = op;
    spec_valid_i = (rand_bits(4) != 32'd0);
    for (int j = 0; j < n_req; j++) begin
      send_request((j == 1 && split) ? op.snd : op.fst,
                   (extra && j == n_req - 1) ? 3'd7 : 3'(rand_bits(3)),
                   merge_done && (j == n_req - 1));
    end
    if (!merge_done) begin
      instr_done_i = 1'b1;
      randomize_side_inputs();
      step_clock();
      instr_done_i = 1'b0;
    end
    spec_valid_i = 1'b0;
  endtask

  task automatic drain_responses();
    int waited;
    waited        = 0;
    csr_access_i  = 1'b0;
    data_rvalid_i = 1'b1;
    while (outstanding_o != '0) begin
      if (waited == DrainTimeout) begin
        $display("Timeout: outstanding responses did not drain in %0d cycles", DrainTimeout);
        fail_run();
      end
      step_clock();
      waited++;
    end
    data_rvalid_i = 1'b0;
  endtask

  initial begin
    rst_n_i       = 1'b0;
    spec_valid_i  = 1'b0;
    spec_op_i     = '0;
    instr_done_i  = 1'b0;
    data_req_i    = 1'b0;
    data_req_o_i  = '0;
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    csr_access_i  = 1'b0;
    csr_addr_i    = '0;
    m_gnt_num     = 0;
    m_count       = 0;
    n_mism        = 0;
    n_unexp       = 0;
    n_rerr        = 0;
    n_csr         = 0;
    repeat (3) @(posedge clk_i);
    #1;
    // Everything quiet while in reset
    check_flag("req_mismatch_o", req_mismatch_o, 1'b0);
    check_flag("unexpected_req_o", unexpected_req_o, 1'b0);
    check_flag("resp_err_o", resp_err_o, 1'b0);
    check_count(outstanding_o, '0);
    check_csr_flag(csr_addr_i, csr_uncheckable_o, 1'b0);
    #1;
    rst_n_i = 1'b1;
    step_clock(); // Idle cycle, outputs still zero
    for (int n = 0; n < NumInstr; n++) begin
      run_instruction();
    end
    drain_responses();
    data_rvalid_i = 1'b1; // Response with nothing owed
    step_clock();
    data_rvalid_i = 1'b0;
    step_clock();
    if (n_mism == 0 || n_unexp == 0 || n_rerr == 0 || n_csr == 0) begin
      $display("Random stimulus never produced one of the flagged events");
      fail_run();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: verilog/csr_check_filter.sv
/*
  CSR check filter
  Flags accesses to CSRs whose values cannot be compared with
  the specification, such as free-running counters
*/
`timescale 1ns/1ns

module csr_check_filter import csr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      csr_access_i,     // CSR instruction in flight
  input  csr_addr_t csr_addr_i,
  output logic      csr_uncheckable_o
);

  logic in_hpm_cnt;    // mhpmcounter3..31
  logic in_hpm_cnt_h;  // mhpmcounter3h..31h
  logic in_hpm_event;  // mhpmevent3..31
  logic is_single;     // One of the listed single addresses
  logic uncheckable;

  // Inclusive range decode
  assign in_hpm_cnt   = (csr_addr_i >= CSR_MHPMCOUNTER3) &&
                        (csr_addr_i <= CSR_MHPMCOUNTER31);
  assign in_hpm_cnt_h = (csr_addr_i >= CSR_MHPMCOUNTER3H) &&
                        (csr_addr_i <= CSR_MHPMCOUNTER31H);
  assign in_hpm_event = (csr_addr_i >= CSR_MHPMEVENT3) &&
                        (csr_addr_i <= CSR_MHPMEVENT31);

  // Model keeps no state for these
  assign is_single = (csr_addr_i == CSR_CPUCTRLSTS)   |
                     (csr_addr_i == CSR_SECURESEED)   | // Random on every read
                     (csr_addr_i == CSR_MIE)          |
                     (csr_addr_i == CSR_MCYCLE)       |
                     (csr_addr_i == CSR_MCYCLEH)      |
                     (csr_addr_i == CSR_MINSTRET)     |
                     (csr_addr_i == CSR_MINSTRETH)    |
                     (csr_addr_i == CSR_MCOUNTINHIBIT);

  assign uncheckable = csr_access_i &
                       (in_hpm_cnt | in_hpm_cnt_h | in_hpm_event | is_single);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      csr_uncheckable_o <= 1'b0;
    end else begin
      csr_uncheckable_o <= uncheckable; // One-cycle flag
    end
  end

endmodule

// File: verilog/csr_pkg.sv
/*
  CSR address type and the machine-mode addresses needed to tell
  checkable CSRs from those whose values drift from the model
*/
package csr_pkg;

  typedef logic [11:0] csr_addr_t; // CSR address field of the instruction

  // Performance counters, low halves
  localparam csr_addr_t CSR_MHPMCOUNTER3  = 12'hB03;
  localparam csr_addr_t CSR_MHPMCOUNTER31 = 12'hB1F;

  // Performance counters, high halves
  localparam csr_addr_t CSR_MHPMCOUNTER3H  = 12'hB83;
  localparam csr_addr_t CSR_MHPMCOUNTER31H = 12'hB9F;

  // Event selectors
  localparam csr_addr_t CSR_MHPMEVENT3  = 12'h323;
  localparam csr_addr_t CSR_MHPMEVENT31 = 12'h33F;

  // Ibex custom CSRs
  localparam csr_addr_t CSR_CPUCTRLSTS = 12'h7C0; // Core control and status
  localparam csr_addr_t CSR_SECURESEED = 12'h7C1; // Reads back random data

  // Interrupt enable
  localparam csr_addr_t CSR_MIE = 12'h304;

  // Cycle and retire counters
  localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
  localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
  localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
  localparam csr_addr_t CSR_MINSTRETH = 12'hB82;

  localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320; // Counter inhibit mask

endpackage

// File: verilog/lsu_conformance_top.sv
/*
  LSU conformance monitor top
  Observes the data bus and CSR accesses of the core and reports
  requests, responses and CSRs that break the expected behaviour
*/
`timescale 1ns/1ns

module lsu_conformance_top import mem_pkg::*, csr_pkg::*; #(
  parameter int unsigned CntWidth = 8 // Outstanding counter width
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Specification side
  input  logic                spec_valid_i,
  input  mem_op_t             spec_op_i,
  input  logic                instr_done_i,
  // Data bus as driven by the core
  input  logic                data_req_i,
  input  bus_req_t            data_req_o_i,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  // CSR side
  input  logic                csr_access_i,
  input  csr_addr_t           csr_addr_i,
  // Results
  output logic                req_mismatch_o,
  output logic                unexpected_req_o,
  output logic                resp_err_o,
  output logic [CntWidth-1:0] outstanding_o,
  output logic                csr_uncheckable_o
);

  // Request compare against the predicted operation
  mem_req_tracker u_mem_req_tracker (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .spec_valid_i     (spec_valid_i),
    .spec_op_i        (spec_op_i),
    .instr_done_i     (instr_done_i),
    .data_req_i       (data_req_i),
    .data_gnt_i       (data_gnt_i),
    .bus_req_i        (data_req_o_i),
    .req_mismatch_o   (req_mismatch_o),
    .unexpected_req_o (unexpected_req_o)
  );

  // Response bookkeeping
  resp_counter #(
    .CntWidth (CntWidth)
  ) u_resp_counter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .data_req_i    (data_req_i),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .outstanding_o (outstanding_o),
    .resp_err_o    (resp_err_o)
  );

  csr_check_filter u_csr_check_filter (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .csr_access_i      (csr_access_i),
    .csr_addr_i        (csr_addr_i),
    .csr_uncheckable_o (csr_uncheckable_o)
  );

endmodule

// File: verilog/mem_pkg.sv
/*
  Data-bus types for the LSU conformance monitor
  Request fields as seen on the core's data port, plus the memory
  operation that the specification predicts for one instruction
*/
package mem_pkg;

  localparam int unsigned WordWidth = 32;                 // Data and address width
  localparam int unsigned ByteWidth = 8;
  localparam int unsigned BeWidth   = WordWidth / ByteWidth; // One enable per byte lane

  typedef logic [WordWidth-1:0] word_t; // Data or address word
  typedef logic [BeWidth-1:0]   be_t;   // Byte enables, bit i covers lane i

  // One outgoing data-bus request, 69 bits
  typedef struct packed {
    logic  we;    // Write when set, read otherwise
    be_t   be;
    word_t addr;  // Word aligned on Ibex
    word_t wdata; // Already shifted to its byte lanes
  } bus_req_t;

  // Expected access for one half of an instruction
  // Neither read nor write set means no request is expected
  typedef struct packed {
    logic  read;
    logic  write;
    word_t addr;
    word_t wdata; // Only meaningful for writes
    be_t   be;    // Lanes that must match on a write
  } mem_half_t;

  // Whole expected operation of one instruction
  // A misaligned access crossing a word boundary uses both halves
  typedef struct packed {
    mem_half_t fst; // First granted request
    mem_half_t snd; // Second request of a split access
  } mem_op_t;

endpackage

// File: verilog/mem_req_tracker.sv
/*
  Memory request tracker
  Counts granted data requests within an instruction and compares
  each one with the expected half of the predicted operation
*/
`timescale 1ns/1ns

module mem_req_tracker import mem_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     spec_valid_i,  // Expected operation is valid
  input  mem_op_t  spec_op_i,     // Held while spec_valid_i is high
  input  logic     instr_done_i,  // Ends the current instruction
  input  logic     data_req_i,
  input  logic     data_gnt_i,
  input  bus_req_t bus_req_i,     // Outgoing request fields
  output logic     req_mismatch_o,
  output logic     unexpected_req_o
);

  logic      req_gnt;      // Request accepted this cycle
  logic      gnt_fst_q;    // First grant seen before now
  logic      gnt_fst_d;
  logic      gnt_snd_q;    // Second grant seen before now
  logic      gnt_snd_d;
  logic      is_snd_req;
  logic      is_third_req;
  logic      snd_expected; // Split access predicted
  mem_half_t exp_half;     // Half that applies to this request
  word_t     byte_mask;
  logic      dir_ok;
  logic      addr_ok;
  logic      wdata_ok;
  logic      unexpected;
  logic      mismatch;

  assign req_gnt = data_req_i & data_gnt_i;

  // Grant position within the instruction
  assign is_snd_req   = req_gnt & gnt_fst_q & ~gnt_snd_q;
  assign is_third_req = req_gnt & gnt_snd_q;

  // Done clears after the grant of the same cycle has been checked
  assign gnt_fst_d = ~instr_done_i & (gnt_fst_q | req_gnt);
  assign gnt_snd_d = ~instr_done_i & (gnt_snd_q | (req_gnt & gnt_fst_q));

  assign exp_half     = gnt_fst_q ? spec_op_i.snd : spec_op_i.fst;
  assign snd_expected = spec_op_i.snd.read | spec_op_i.snd.write;

  // Expand byte enables to a bit mask
  always_comb begin
    byte_mask = '0;
    for (int i = 0; i < BeWidth; i++) begin
      byte_mask[i*ByteWidth +: ByteWidth] = {ByteWidth{exp_half.be[i]}};
    end
  end

  // Direction must agree both ways, so a half with no access never matches
  assign dir_ok  = (exp_half.write == bus_req_i.we) && (exp_half.read == ~bus_req_i.we);
  assign addr_ok = (bus_req_i.addr == exp_half.addr);

  // Disabled lanes may carry anything
  assign wdata_ok = ~bus_req_i.we |
                    ((bus_req_i.wdata & byte_mask) == (exp_half.wdata & byte_mask));

  // Request that should not exist at all
  assign unexpected = req_gnt & (~spec_valid_i |
                                 (is_snd_req & ~snd_expected) |
                                 is_third_req);

  // Wrong fields on a request that was expected
  assign mismatch = req_gnt & ~unexpected & ~(dir_ok & addr_ok & wdata_ok);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      gnt_fst_q        <= 1'b0;
      gnt_snd_q        <= 1'b0;
      req_mismatch_o   <= 1'b0;
      unexpected_req_o <= 1'b0;
    end else begin
      gnt_fst_q        <= gnt_fst_d;
      gnt_snd_q        <= gnt_snd_d;
      req_mismatch_o   <= mismatch;   // One cycle after the grant
      unexpected_req_o <= unexpected;
    end
  end

endmodule

// File: verilog/resp_counter.sv
/*
  Outstanding response counter
  Tracks granted data requests still waiting for rvalid and flags
  a response that arrives with nothing outstanding
*/
`timescale 1ns/1ns

module resp_counter #(
  parameter int unsigned CntWidth = 8
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                data_req_i,
  input  logic                data_gnt_i,
  input  logic                data_rvalid_i,
  output logic [CntWidth-1:0] outstanding_o,
  output logic                resp_err_o     // Response with none outstanding
);

  logic                req_gnt;
  logic [CntWidth-1:0] count_q;
  logic [CntWidth-1:0] count_d;
  logic                at_max;
  logic                at_zero;

  assign req_gnt = data_req_i & data_gnt_i;
  assign at_max  = &count_q;
  assign at_zero = ~|count_q;

  // Saturating up/down count
  always_comb begin
    count_d = count_q;
    case ({req_gnt, data_rvalid_i})
      2'b10:   if (!at_max) count_d = count_q + CntWidth'(1);
      2'b01:   if (!at_zero) count_d = count_q - CntWidth'(1);
      default: count_d = count_q; // Idle, or a grant and a response cancel out
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q    <= '0;
      resp_err_o <= 1'b0;
    end else begin
      count_q    <= count_d;
      resp_err_o <= data_rvalid_i & at_zero; // Judged on the registered count
    end
  end

  assign outstanding_o = count_q;

endmodule
